// ==== bench/lsu_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts
    import mem_access_pkg::*;
    import store_buffer_pkg::*;
(
    input logic                clk,
    input logic                arst_n,
    input logic                store_valid,
    input logic                load_valid,
    input logic                store_stall,
    input logic [SB_PTR_W-1:0] head,
    input logic [SB_PTR_W-1:0] tail,
    input logic                mem_wr_valid,
    input logic [XLEN-1:0]     mem_wr_addr,
    input logic                mem_busy,
    input logic                sb_empty
);

    int n_fail = 0;   // Failed assertion count

    // One memory operation per cycle from the issue stage
    a_one_op: assert property (@(posedge clk) disable iff (!arst_n)
        !(store_valid && load_valid))
        else begin
            $error("store_valid and load_valid high together");
            n_fail++;
        end

    // Full means the pointers meet while entries are still held
    a_stall_full: assert property (@(posedge clk) disable iff (!arst_n)
        store_stall == (head == tail && !sb_empty))
        else begin
            $error("store_stall differs from buffer full");
            n_fail++;
        end

    // Head write waits out the busy cycle unchanged
    a_busy_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_wr_valid && mem_busy) |=> (mem_wr_valid && $stable(mem_wr_addr)))
        else begin
            $error("write request dropped or changed under mem_busy");
            n_fail++;
        end

    a_empty_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !(sb_empty && mem_wr_valid))
        else begin
            $error("sb_empty high with a pending memory write");
            n_fail++;
        end

endmodule

bind store_buffer lsu_asserts u_asserts (.*);

`default_nettype wire

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import mem_access_pkg::*;
    import store_buffer_pkg::*;
;

    typedef enum logic [2:0] {
        OP_IDLE, OP_STORE, OP_LOAD, OP_COMMIT, OP_FLUSH, OP_WAIT_EMPTY, OP_TRY_STORE
    } op_e;

    logic                 clk;
    logic                 arst_n;
    logic                 store_valid;
    logic                 load_valid;
    logic [XLEN-1:0]      addr;
    logic [XLEN-1:0]      wdata;
    mem_width_e           funct3;
    logic [ROB_IDX_W-1:0] rob_idx;
    logic                 commit_valid;
    logic [ROB_IDX_W-1:0] commit_rob_idx;
    logic                 flush;
    logic                 store_stall;
    logic                 load_stall;
    logic                 load_done;
    logic [XLEN-1:0]      load_data;
    logic                 load_forwarded;
    logic                 sb_empty;

    // Step table
    op_e        t_op    [80];
    logic [31:0] t_addr [80];
    logic [31:0] t_wdata[80];
    mem_width_e t_f3    [80];
    logic [3:0] t_rob   [80];
    logic [31:0] t_exp  [80];
    logic       t_fwd   [80];
    logic       t_stall [80];
    int         n_steps = 0;
    int         errors  = 0;
    int         n_assert;

    // Shadow memory and pending store list with the oldest entry first
    logic [7:0]  smem [0:1023];
    logic [31:0] q_addr[$];
    logic [31:0] q_data[$];
    logic [3:0]  q_strb[$];
    logic [3:0]  q_rob[$];
    bit          q_comm[$];

    lsu_top uut (.*);

    always #50 clk = ~clk;

    task automatic add(input op_e op, input logic [31:0] a, input logic [31:0] d,
                       input mem_width_e f, input logic [3:0] r, input logic [31:0] e,
                       input logic fw, input logic st);
        t_op[n_steps]    = op;
        t_addr[n_steps]  = a;
        t_wdata[n_steps] = d;
        t_f3[n_steps]    = f;
        t_rob[n_steps]   = r;
        t_exp[n_steps]   = e;
        t_fwd[n_steps]   = fw;
        t_stall[n_steps] = st;
        n_steps++;
    endtask

    function automatic logic [3:0] lane_strb(input logic [31:0] a, input mem_width_e f);
        case (f)
            WIDTH_B, WIDTH_BU: return 4'b0001 << a[1:0];
            WIDTH_H, WIDTH_HU: return a[1] ? 4'b1100 : 4'b0011;
            default:           return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] placed(input logic [31:0] a, input logic [31:0] d,
                                           input mem_width_e f);
        case (f)
            WIDTH_B: return {24'b0, d[7:0]} << (8 * a[1:0]);
            WIDTH_H: return {16'b0, d[15:0]} << (8 * a[1:0]);
            default: return d;
        endcase
    endfunction

    function automatic logic [31:0] extend(input logic [31:0] w, input logic [1:0] off,
                                           input mem_width_e f);
        logic [31:0] sh;
        sh = w >> (8 * off);
        case (f)
            WIDTH_B:  return {{24{sh[7]}}, sh[7:0]};
            WIDTH_BU: return {24'b0, sh[7:0]};
            WIDTH_H:  return {{16{sh[15]}}, sh[15:0]};
            WIDTH_HU: return {16'b0, sh[15:0]};
            default:  return w;
        endcase
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] wa);
        return {smem[wa[9:0]+3], smem[wa[9:0]+2], smem[wa[9:0]+1], smem[wa[9:0]]};
    endfunction

    // Write out the committed prefix oldest first
    task automatic drain_committed();
        while (q_comm.size() > 0 && q_comm[0]) begin
            for (int b = 0; b < 4; b++) begin
                if (q_strb[0][b])
                    smem[q_addr[0][9:0] + b] = q_data[0][8*b +: 8];
            end
            void'(q_addr.pop_front());
            void'(q_data.pop_front());
            void'(q_strb.pop_front());
            void'(q_rob.pop_front());
            void'(q_comm.pop_front());
        end
    endtask

    task automatic model_load(input logic [31:0] a, input mem_width_e f,
                              output logic [31:0] val, output logic fw);
        logic [31:0] wa;
        logic [3:0]  ls;
        logic [31:0] word;
        bit          found;
        wa    = {a[31:2], 2'b00};
        ls    = lane_strb(a, f);
        found = 0;
        fw    = 0;
        for (int i = q_addr.size() - 1; i >= 0; i--) begin
            if (!found && q_addr[i] == wa && |(q_strb[i] & ls)) begin
                found = 1;
                fw    = ((q_strb[i] & ls) == ls);
                word  = q_data[i];
            end
        end
        if (found && !fw)
            drain_committed();   // Partial overlap waits for the drain
        if (!fw)
            word = shadow_word(wa);
        val = extend(word, a[1:0], f);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic run_step(input int i);
        logic        s;
        int          stalls;
        int          waited;
        logic [31:0] m_val;
        logic        m_fw;
        stalls         = 0;
        store_valid    = 0;
        load_valid     = 0;
        commit_valid   = 0;
        flush          = 0;
        addr           = t_addr[i];
        wdata          = t_wdata[i];
        funct3         = t_f3[i];
        rob_idx        = t_rob[i];
        commit_rob_idx = t_rob[i];
        case (t_op[i])
            OP_STORE, OP_TRY_STORE: begin
                store_valid = 1;
                do begin
                    #10 s = store_stall;
                    @(negedge clk);
                    if (s)
                        stalls++;
                end while (s && t_op[i] == OP_STORE);
                store_valid = 0;
                if (t_op[i] == OP_TRY_STORE) begin
                    check("store_stall", s, 1);
                end else begin
                    q_addr.push_back({t_addr[i][31:2], 2'b00});
                    q_data.push_back(placed(t_addr[i], t_wdata[i], t_f3[i]));
                    q_strb.push_back(lane_strb(t_addr[i], t_f3[i]));
                    q_rob.push_back(t_rob[i]);
                    q_comm.push_back(0);
                end
            end
            OP_LOAD: begin
                load_valid = 1;
                do begin
                    #10 s = load_stall;
                    @(negedge clk);
                    if (s)
                        stalls++;
                end while (s);
                load_valid = 0;
                model_load(t_addr[i], t_f3[i], m_val, m_fw);
                if (m_val !== t_exp[i] || m_fw !== t_fwd[i]) begin
                    errors++;
                    $display("Shadow model disagrees with the expected value of step %0d", i);
                end
                if ((stalls > 0) != t_stall[i]) begin
                    errors++;
                    $display("Load of step %0d stalled %0d cycles, not as expected", i, stalls);
                end
                check("load_done", load_done, 1);
                check("load_data", load_data, t_exp[i]);
                check("load_forwarded", load_forwarded, t_fwd[i]);
            end
            OP_COMMIT: begin
                commit_valid = 1;
                foreach (q_comm[k]) begin
                    if (!q_comm[k] && q_rob[k] == t_rob[i]) begin
                        q_comm[k] = 1;
                        break;
                    end
                end
                @(negedge clk);
            end
            OP_FLUSH: begin
                flush = 1;
                while (q_comm.size() > 0 && !q_comm[q_comm.size()-1]) begin
                    void'(q_addr.pop_back());
                    void'(q_data.pop_back());
                    void'(q_strb.pop_back());
                    void'(q_rob.pop_back());
                    void'(q_comm.pop_back());
                end
                @(negedge clk);
            end
            OP_WAIT_EMPTY: begin
                waited = 0;
                while (!sb_empty && waited < 100) begin
                    @(negedge clk);
                    waited++;
                end
                if (!sb_empty) begin
                    errors++;
                    $display("Store buffer did not empty at step %0d", i);
                end
                check("load_done", load_done, 0);   // No load in flight here
                drain_committed();
            end
            default: @(negedge clk);
        endcase
        commit_valid = 0;
        flush        = 0;
    endtask

    task automatic build_table();
        add(OP_STORE, 'h010, 'h11223344, WIDTH_W, 1, 0, 0, 0);   // Forward before commit
        add(OP_LOAD,  'h010, 0, WIDTH_W, 0, 'h11223344, 1, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 1, 0, 0, 0);
        add(OP_STORE, 'h020, 'hAAAA0001, WIDTH_W, 2, 0, 0, 0);   // Younger store wins
        add(OP_STORE, 'h020, 'hBBBB0002, WIDTH_W, 3, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 2, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 3, 0, 0, 0);
        add(OP_WAIT_EMPTY, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_LOAD,  'h020, 0, WIDTH_W, 0, 'hBBBB0002, 0, 0);
        add(OP_STORE, 'h030, 'h81, WIDTH_B, 4, 0, 0, 0);         // Byte lanes
        add(OP_STORE, 'h031, 'h02, WIDTH_B, 5, 0, 0, 0);
        add(OP_STORE, 'h032, 'hF3, WIDTH_B, 6, 0, 0, 0);
        add(OP_STORE, 'h033, 'h04, WIDTH_B, 7, 0, 0, 0);
        for (int r = 4; r < 8; r++)
            add(OP_COMMIT, 0, 0, WIDTH_W, r, 0, 0, 0);
        add(OP_WAIT_EMPTY, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_LOAD, 'h030, 0, WIDTH_B,  0, 'hFFFFFF81, 0, 0);
        add(OP_LOAD, 'h030, 0, WIDTH_BU, 0, 'h00000081, 0, 0);
        add(OP_LOAD, 'h031, 0, WIDTH_B,  0, 'h00000002, 0, 0);
        add(OP_LOAD, 'h032, 0, WIDTH_B,  0, 'hFFFFFFF3, 0, 0);
        add(OP_LOAD, 'h033, 0, WIDTH_BU, 0, 'h00000004, 0, 0);
        add(OP_LOAD, 'h030, 0, WIDTH_H,  0, 'h00000281, 0, 0);
        add(OP_LOAD, 'h032, 0, WIDTH_HU, 0, 'h000004F3, 0, 0);
        add(OP_LOAD, 'h030, 0, WIDTH_W,  0, 'h04F30281, 0, 0);
        add(OP_STORE, 'h040, 'h8001, WIDTH_H, 8, 0, 0, 0);       // Halfword lanes
        add(OP_STORE, 'h042, 'h7FFE, WIDTH_H, 9, 0, 0, 0);
        add(OP_LOAD, 'h040, 0, WIDTH_H,  0, 'hFFFF8001, 1, 0);
        add(OP_LOAD, 'h042, 0, WIDTH_HU, 0, 'h00007FFE, 1, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 8, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 9, 0, 0, 0);
        add(OP_WAIT_EMPTY, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_LOAD, 'h040, 0, WIDTH_W,  0, 'h7FFE8001, 0, 0);
        add(OP_LOAD, 'h040, 0, WIDTH_HU, 0, 'h00008001, 0, 0);
        add(OP_STORE, 'h050, 'h50505050, WIDTH_W, 10, 0, 0, 0);  // Flush keeps committed
        add(OP_STORE, 'h054, 'h54545454, WIDTH_W, 11, 0, 0, 0);
        add(OP_STORE, 'h030, 'hDEADBEEF, WIDTH_W, 12, 0, 0, 0);
        add(OP_STORE, 'h040, 'hCAFEF00D, WIDTH_W, 13, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 10, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 11, 0, 0, 0);
        add(OP_FLUSH, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_WAIT_EMPTY, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_LOAD, 'h050, 0, WIDTH_W, 0, 'h50505050, 0, 0);
        add(OP_LOAD, 'h054, 0, WIDTH_W, 0, 'h54545454, 0, 0);
        add(OP_LOAD, 'h030, 0, WIDTH_W, 0, 'h04F30281, 0, 0);
        add(OP_LOAD, 'h040, 0, WIDTH_W, 0, 'h7FFE8001, 0, 0);
        for (int r = 0; r < 4; r++)                               // Fill the buffer
            add(OP_STORE, 'h060 + 4*r, {4{8'h60 + 8'(4*r)}}, WIDTH_W, r, 0, 0, 0);
        add(OP_TRY_STORE, 'h070, 'h70707070, WIDTH_W, 4, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_STORE, 'h070, 'h70707070, WIDTH_W, 4, 0, 0, 0);
        for (int r = 1; r < 5; r++)
            add(OP_COMMIT, 0, 0, WIDTH_W, r, 0, 0, 0);
        add(OP_WAIT_EMPTY, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_LOAD, 'h070, 0, WIDTH_W, 0, 'h70707070, 0, 0);
        add(OP_LOAD, 'h06C, 0, WIDTH_W, 0, 'h6C6C6C6C, 0, 0);
        add(OP_STORE, 'h080, 'h11223344, WIDTH_W, 5, 0, 0, 0);   // Partial overlap stall
        add(OP_COMMIT, 0, 0, WIDTH_W, 5, 0, 0, 0);
        add(OP_WAIT_EMPTY, 0, 0, WIDTH_W, 0, 0, 0, 0);
        add(OP_STORE, 'h081, 'hA5, WIDTH_B, 6, 0, 0, 0);
        add(OP_COMMIT, 0, 0, WIDTH_W, 6, 0, 0, 0);
        add(OP_LOAD, 'h080, 0, WIDTH_W, 0, 'h1122A544, 0, 1);
        add(OP_IDLE, 0, 0, WIDTH_W, 0, 0, 0, 0);
    endtask

    initial begin
        #1;
        #(n_steps * 200 * 100);
        $display("Watchdog expired before the table finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        clk            = 0;
        arst_n         = 0;
        store_valid    = 0;
        load_valid     = 0;
        addr           = '0;
        wdata          = '0;
        funct3         = WIDTH_W;
        rob_idx        = '0;
        commit_valid   = 0;
        commit_rob_idx = '0;
        flush          = 0;
        for (int b = 0; b < 1024; b++)
            smem[b] = 8'h00;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1;
        for (int i = 0; i < n_steps; i++)
            run_step(i);
        n_assert = uut.u_sb.u_asserts.n_fail;
        $display("Run finished with %0d check errors and %0d assertion failures",
                 errors, n_assert);
        if (errors == 0 && n_assert == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/mem_access_pkg.sv
hw/store_buffer_pkg.sv
hw/store_align.sv
hw/store_buffer.sv
hw/load_align.sv
hw/data_mem.sv
hw/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv

// ==== hw/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem import mem_access_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              mem_wr_valid,
    input  logic [XLEN-1:0]   mem_wr_addr,
    input  logic [XLEN-1:0]   mem_wr_data,
    input  logic [STRB_W-1:0] mem_wr_strb,
    input  logic [XLEN-1:0]   rd_addr,
    output logic              mem_busy,
    output logic [XLEN-1:0]   mem_rd_data
);

    logic [XLEN-1:0] mem [MEM_WORDS];

    logic                 wr_fire;
    logic [MEM_IDX_W-1:0] wr_idx;
    logic [MEM_IDX_W-1:0] rd_idx;

    assign wr_fire = mem_wr_valid && !mem_busy;
    assign wr_idx  = mem_wr_addr[MEM_IDX_W+1:2];
    assign rd_idx  = rd_addr[MEM_IDX_W+1:2];

    // Combinational read port
    assign mem_rd_data = mem[rd_idx];

    // Busy for one cycle after every accepted write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            mem_busy <= 1'b0;
        else
            mem_busy <= wr_fire;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < MEM_WORDS; w++)
                mem[w] <= '0;             // Memory starts out zeroed
        end else if (wr_fire) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (mem_wr_strb[b])
                    mem[wr_idx][8*b +: 8] <= mem_wr_data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align import mem_access_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            load_go,
    input  logic [1:0]      ld_byte_off,
    input  mem_width_e      ld_funct3,
    input  logic            fwd_hit,
    input  logic [XLEN-1:0] fwd_data,
    input  logic [XLEN-1:0] mem_rd_data,
    output logic            load_done,
    output logic [XLEN-1:0] load_data,
    output logic            load_forwarded
);

    logic [XLEN-1:0] word;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] result;

    assign word    = fwd_hit ? fwd_data : mem_rd_data;
    assign ld_byte = word[8*ld_byte_off +: 8];
    assign ld_half = ld_byte_off[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (ld_funct3)
            WIDTH_B:  result = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            WIDTH_BU: result = {{(XLEN-8){1'b0}}, ld_byte};
            WIDTH_H:  result = {{(XLEN-16){ld_half[15]}}, ld_half};
            WIDTH_HU: result = {{(XLEN-16){1'b0}}, ld_half};
            default:  result = word;                  // Full word
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_done      <= 1'b0;
            load_forwarded <= 1'b0;
        end else begin
            load_done      <= load_go;   // One-cycle pulse per accepted load
            load_forwarded <= load_go && fwd_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (load_go)
            load_data <= result;
    end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import mem_access_pkg::*;
    import store_buffer_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 store_valid,
    input  logic                 load_valid,
    input  logic [XLEN-1:0]      addr,
    input  logic [XLEN-1:0]      wdata,
    input  mem_width_e           funct3,
    input  logic [ROB_IDX_W-1:0] rob_idx,
    input  logic                 commit_valid,
    input  logic [ROB_IDX_W-1:0] commit_rob_idx,
    input  logic                 flush,
    output logic                 store_stall,
    output logic                 load_stall,
    output logic                 load_done,
    output logic [XLEN-1:0]      load_data,
    output logic                 load_forwarded,
    output logic                 sb_empty
);

    // Store path
    logic [XLEN-1:0] st_word_addr;
    logic [XLEN-1:0] st_data;
    logic [3:0]      st_strb;

    // Load lookup
    logic [XLEN-1:0] ld_word_addr;
    logic [3:0]      ld_strb;
    logic            fwd_hit;
    logic [XLEN-1:0] fwd_data;

    // Memory side
    logic            mem_wr_valid;
    logic [XLEN-1:0] mem_wr_addr;
    logic [XLEN-1:0] mem_wr_data;
    logic [3:0]      mem_wr_strb;
    logic            mem_busy;
    logic [XLEN-1:0] mem_rd_data;

    store_align u_st_align (
        .addr(addr), .wdata(wdata), .funct3(funct3),
        .st_word_addr(st_word_addr), .st_data(st_data), .st_strb(st_strb)
    );

    // Same lane logic gives the load strobe, data output not needed here
    store_align u_ld_strb (
        .addr(addr), .wdata(wdata), .funct3(funct3),
        .st_word_addr(ld_word_addr), .st_data(), .st_strb(ld_strb)
    );

    store_buffer u_sb (
        .clk(clk), .arst_n(arst_n),
        .store_valid(store_valid), .st_word_addr(st_word_addr),
        .st_data(st_data), .st_strb(st_strb), .rob_idx(rob_idx),
        .commit_valid(commit_valid), .commit_rob_idx(commit_rob_idx), .flush(flush),
        .load_valid(load_valid), .ld_word_addr(ld_word_addr), .ld_strb(ld_strb),
        .mem_busy(mem_busy), .store_stall(store_stall), .load_stall(load_stall),
        .fwd_hit(fwd_hit), .fwd_data(fwd_data),
        .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_strb(mem_wr_strb), .sb_empty(sb_empty)
    );

    data_mem u_mem (
        .clk(clk), .arst_n(arst_n),
        .mem_wr_valid(mem_wr_valid), .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data), .mem_wr_strb(mem_wr_strb),
        .rd_addr(ld_word_addr), .mem_busy(mem_busy), .mem_rd_data(mem_rd_data)
    );

    load_align u_ld (
        .clk(clk), .arst_n(arst_n),
        .load_go(load_valid && !load_stall),   // Accepted load
        .ld_byte_off(addr[1:0]), .ld_funct3(funct3),
        .fwd_hit(fwd_hit), .fwd_data(fwd_data), .mem_rd_data(mem_rd_data),
        .load_done(load_done), .load_data(load_data), .load_forwarded(load_forwarded)
    );

endmodule

`default_nettype wire

// ==== hw/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

    // Address and data path width
    localparam int XLEN = 32;

    // Data memory depth in words, indexed by address bits 9 to 2
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Byte lanes per data word
    localparam int STRB_W = XLEN / 8;

    // Access width, same encoding as RV32 load/store funct3
    typedef enum logic [2:0] {
        WIDTH_B  = 3'b000,
        WIDTH_H  = 3'b001,
        WIDTH_W  = 3'b010,
        WIDTH_BU = 3'b100,
        WIDTH_HU = 3'b101
    } mem_width_e;

endpackage

`default_nettype wire

// ==== hw/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align import mem_access_pkg::*; (
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    input  mem_width_e      funct3,
    output logic [XLEN-1:0] st_word_addr,
    output logic [XLEN-1:0] st_data,
    output logic [3:0]      st_strb
);

    assign st_word_addr = {addr[XLEN-1:2], 2'b00};

    always_comb begin
        case (funct3)
            WIDTH_B, WIDTH_BU: begin
                st_data = {4{wdata[7:0]}};           // Same byte in every lane
                st_strb = 4'b0001 << addr[1:0];
            end
            WIDTH_H, WIDTH_HU: begin
                st_data = {2{wdata[15:0]}};
                st_strb = addr[1] ? 4'b1100 : 4'b0011;
            end
            WIDTH_W: begin
                st_data = wdata;
                st_strb = 4'b1111;
            end
            default: begin
                // Unused funct3 codes touch no lanes
                st_data = wdata;
                st_strb = 4'b0000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/store_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_buffer
    import mem_access_pkg::*;
    import store_buffer_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 store_valid,
    input  logic [XLEN-1:0]      st_word_addr,
    input  logic [XLEN-1:0]      st_data,
    input  logic [3:0]           st_strb,
    input  logic [ROB_IDX_W-1:0] rob_idx,
    input  logic                 commit_valid,
    input  logic [ROB_IDX_W-1:0] commit_rob_idx,
    input  logic                 flush,
    input  logic                 load_valid,
    input  logic [XLEN-1:0]      ld_word_addr,
    input  logic [3:0]           ld_strb,
    input  logic                 mem_busy,
    output logic                 store_stall,
    output logic                 load_stall,
    output logic                 fwd_hit,
    output logic [XLEN-1:0]      fwd_data,
    output logic                 mem_wr_valid,
    output logic [XLEN-1:0]      mem_wr_addr,
    output logic [XLEN-1:0]      mem_wr_data,
    output logic [3:0]           mem_wr_strb,
    output logic                 sb_empty
);

    // Entry array
    sb_state_e            ent_state [SB_DEPTH];
    logic [ROB_IDX_W-1:0] ent_rob   [SB_DEPTH];
    logic [XLEN-1:0]      ent_addr  [SB_DEPTH];
    logic [XLEN-1:0]      ent_data  [SB_DEPTH];
    logic [3:0]           ent_strb  [SB_DEPTH];

    logic [SB_PTR_W-1:0] head;     // Oldest entry
    logic [SB_PTR_W-1:0] tail;     // Next slot to allocate
    logic [SB_CNT_W-1:0] count;
    logic [SB_CNT_W-1:0] n_comm;   // Committed entries, always a prefix from head

    logic full;
    logic st_accept;
    logic drain;

    // Forwarding search
    logic [SB_PTR_W-1:0] idx;
    logic                found;
    logic [3:0]          m_strb;
    logic [XLEN-1:0]     m_data;
    logic                covered;

    assign full        = (count == SB_CNT_W'(SB_DEPTH));
    assign store_stall = full;
    assign st_accept   = store_valid && !full;
    assign sb_empty    = (count == '0);

    // Drain port, head entry goes out once the ROB has committed it
    assign mem_wr_valid = (ent_state[head] == SB_COMMITTED);
    assign mem_wr_addr  = ent_addr[head];
    assign mem_wr_data  = ent_data[head];
    assign mem_wr_strb  = ent_strb[head];
    assign drain        = mem_wr_valid && !mem_busy;

    always_comb begin
        n_comm = '0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (ent_state[i] == SB_COMMITTED)
                n_comm = n_comm + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < SB_DEPTH; i++)
                ent_state[i] <= SB_FREE;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (drain) begin
                ent_state[head] <= SB_FREE;
                head            <= head + 1'b1;
            end
            if (flush) begin
                // Drop speculative stores, committed ones stay and drain
                for (int i = 0; i < SB_DEPTH; i++) begin
                    if (ent_state[i] == SB_SPEC)
                        ent_state[i] <= SB_FREE;
                end
                tail  <= head + n_comm[SB_PTR_W-1:0];
                count <= n_comm - SB_CNT_W'(drain);
            end else begin
                if (commit_valid) begin
                    for (int i = 0; i < SB_DEPTH; i++) begin
                        if (ent_state[i] == SB_SPEC && ent_rob[i] == commit_rob_idx)
                            ent_state[i] <= SB_COMMITTED;
                    end
                end
                if (st_accept) begin
                    ent_state[tail] <= SB_SPEC;
                    tail            <= tail + 1'b1;
                end
                count <= count + SB_CNT_W'(st_accept) - SB_CNT_W'(drain);
            end
        end
    end

    // Payload, written only at allocation
    always_ff @(posedge clk) begin
        if (st_accept && !flush) begin
            ent_rob[tail]  <= rob_idx;
            ent_addr[tail] <= st_word_addr;
            ent_data[tail] <= st_data;
            ent_strb[tail] <= st_strb;
        end
    end

    // Walk from the youngest slot back to head, first overlap wins
    always_comb begin
        found  = 1'b0;
        m_strb = '0;
        m_data = '0;
        idx    = head;
        for (int k = SB_DEPTH - 1; k >= 0; k--) begin
            idx = head + SB_PTR_W'(k);
            if (!found && ent_state[idx] != SB_FREE &&
                ent_addr[idx] == ld_word_addr && |(ent_strb[idx] & ld_strb)) begin
                found  = 1'b1;
                m_strb = ent_strb[idx];
                m_data = ent_data[idx];
            end
        end
    end

    assign covered    = ((m_strb & ld_strb) == ld_strb);
    assign fwd_hit    = found && covered;
    assign fwd_data   = m_data;
    assign load_stall = load_valid && found && !covered;   // Partial overlap waits for drain

endmodule

`default_nettype wire

// ==== hw/store_buffer_pkg.sv ====
`default_nettype none

package store_buffer_pkg;

    // Number of store buffer entries
    localparam int SB_DEPTH = 4;
    localparam int SB_PTR_W = 2;   // Head and tail pointer width

    // Occupancy counter needs one bit more than the pointers
    localparam int SB_CNT_W = SB_PTR_W + 1;

    // Width of a reorder buffer tag
    localparam int ROB_IDX_W = 4;

    // Lifecycle of one entry
    typedef enum logic [1:0] {
        SB_FREE      = 2'b00,
        SB_SPEC      = 2'b01,  // Allocated, waiting for the ROB
        SB_COMMITTED = 2'b10   // Waiting to drain to memory
    } sb_state_e;

endpackage

`default_nettype wire
